/* sim.f */
logic/elastic_pkg.sv
logic/symbol_ingress.sv
logic/symbol_write.sv
logic/symbol_ram.sv
logic/buffer_read.sv
logic/lane_buffer.sv
logic/lane_status.sv
logic/elastic_top.sv
tests/elastic_chk.sv
tests/elastic_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the elastic buffer testbench with Verilator and runs it.
# The simulator's exit status is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module elastic_tb \
    -f sim.f \
    -o elastic_sim

./obj_dir/elastic_sim

/* tests/elastic_tb.sv */
`timescale 1ns/1ns

module elastic_tb
    import elastic_pkg::*;
();

    localparam int lane_count = 2;
    localparam int test_count = 6;
    localparam int drain_cycles = 48;

    // Expected flags come as a value and a mask of the lanes that matter
    typedef struct packed {
        logic [lane_count-1:0] enable;
        int                    count;
        int                    gap;
        int                    interval;
        logic [lane_count-1:0] stop;
        logic                  check_order;
        logic [lane_count-1:0] ovf_exp;
        logic [lane_count-1:0] ovf_care;
        logic [lane_count-1:0] unf_exp;
        logic [lane_count-1:0] unf_care;
        logic [lane_count-1:0] add_exp;
        logic [lane_count-1:0] add_care;
        logic [lane_count-1:0] rem_exp;
        logic [lane_count-1:0] rem_care;
    } test_row_t;

    logic                                local_clock;
    logic                                local_reset;
    lane_symbol_t [lane_count-1:0]       lane_in;
    logic         [lane_count-1:0]       lane_enable;
    logic         [lane_count-1:0]       link_up;
    symbol_t      [lane_count-1:0]       symbol_out;
    logic         [lane_count-1:0]       skip_added;
    logic         [lane_count-1:0]       overflow_seen;
    logic         [lane_count-1:0]       underflow_seen;
    logic         [lane_count-1:0][7:0]  added_count;
    logic         [lane_count-1:0][7:0]  removed_count;

    string                 test_names [test_count];
    test_row_t             tests [test_count];
    integer                seed;
    symbol_t               sent_q [lane_count][$];
    symbol_t               received_q [lane_count][$];
    int                    comma_sent [lane_count];
    logic [lane_count-1:0] pulse_seen;
    logic                  collecting;
    logic                  table_ready;
    string                 current_test;

    elastic_top #(
        .lane_count    (lane_count),
        .address_width (4)
    ) elastic_top_i (
        .local_clock    (local_clock),
        .local_reset    (local_reset),
        .lane_in        (lane_in),
        .lane_enable    (lane_enable),
        .link_up        (link_up),
        .symbol_out     (symbol_out),
        .skip_added     (skip_added),
        .overflow_seen  (overflow_seen),
        .underflow_seen (underflow_seen),
        .added_count    (added_count),
        .removed_count  (removed_count)
    );

    initial begin
        local_clock = 1'b0;
        forever #2 local_clock = ~local_clock;
    end

    task automatic check_value(input string what, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h",
                     current_test, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Payload never collides with the control codes or the zero of an unwritten RAM
    function automatic symbol_t next_payload();
        symbol_t value;
        value = 10'($random(seed));
        while (value == comma_symbol || value == skip_symbol || value == '0) begin
            value = 10'($random(seed));
        end
        return value;
    endfunction

    function automatic symbol_t stream_symbol(input int index, input int interval);
        if (index % interval == 0) begin
            return comma_symbol;
        end else if (index % interval == 1) begin
            return skip_symbol;
        end
        return next_payload();
    endfunction

    // Longest unbroken run of the sent stream found anywhere in the received one
    function automatic int aligned_match_length(input int lane);
        int best;
        int run;
        best = 0;
        for (int k = 0; k < received_q[lane].size(); k++) begin
            run = 0;
            while (run < sent_q[lane].size() && k + run < received_q[lane].size() &&
                   received_q[lane][k + run] == sent_q[lane][run]) begin
                run++;
            end
            if (run > best) begin
                best = run;
            end
        end
        return best;
    endfunction

    task automatic reset_dut(input logic [lane_count-1:0] enable);
        @(posedge local_clock);
        local_reset <= 1'b0;
        lane_in <= '0;
        lane_enable <= enable;
        repeat (3) @(posedge local_clock);
        local_reset <= 1'b1;
    endtask

    task automatic check_reset_state();
        @(negedge local_clock);
        check_value("link_up after reset", 0, longint'(link_up));
        check_value("skip_added after reset", 0, longint'(skip_added));
        check_value("overflow_seen after reset", 0, longint'(overflow_seen));
        check_value("underflow_seen after reset", 0, longint'(underflow_seen));
        check_value("added_count after reset", 0, longint'(added_count));
        check_value("removed_count after reset", 0, longint'(removed_count));
    endtask

    task automatic drive_symbols(input test_row_t row);
        int      cycle;
        int      sent;
        symbol_t value;
        cycle = 0;
        sent = 0;
        while (sent < row.count) begin
            @(posedge local_clock);
            if (row.gap != 0 && cycle % row.gap == row.gap - 1) begin
                lane_in <= '0;
            end else begin
                for (int i = 0; i < lane_count; i++) begin
                    value = stream_symbol(sent, row.interval);
                    lane_in[i] <= '{symbol: value, valid: 1'b1};
                    if (row.enable[i] && value != skip_symbol) begin
                        sent_q[i].push_back(value);
                    end
                    if (row.enable[i] && value == comma_symbol) begin
                        comma_sent[i]++;
                    end
                end
                sent++;
            end
            cycle++;
        end
        // Trailing skips keep the buffer fed while it drains, except on stopped lanes
        repeat (drain_cycles) begin
            @(posedge local_clock);
            for (int i = 0; i < lane_count; i++) begin
                lane_in[i] <= '{symbol: skip_symbol, valid: !row.stop[i]};
            end
        end
        @(negedge local_clock);
    endtask

    // Received symbols must hold the sent stream unbroken, skips left out
    task automatic check_results(input test_row_t row);
        for (int i = 0; i < lane_count; i++) begin
            if (row.check_order && row.enable[i]) begin
                check_value($sformatf("lane %0d symbols in order", i),
                            longint'(sent_q[i].size()), longint'(aligned_match_length(i)));
            end
            check_value($sformatf("lane %0d link_up", i),
                        longint'(row.enable[i] && comma_sent[i] >= 4), longint'(link_up[i]));
            if (row.add_care[i]) begin
                check_value($sformatf("lane %0d added_count nonzero", i),
                            longint'(row.add_exp[i]), longint'(added_count[i] != 0));
                check_value($sformatf("lane %0d skip_added pulse seen", i),
                            longint'(row.add_exp[i]), longint'(pulse_seen[i]));
            end
            if (row.rem_care[i]) begin
                check_value($sformatf("lane %0d removed_count nonzero", i),
                            longint'(row.rem_exp[i]), longint'(removed_count[i] != 0));
            end
        end
        check_value("overflow_seen", longint'(row.ovf_exp & row.ovf_care),
                    longint'(overflow_seen & row.ovf_care));
        check_value("underflow_seen", longint'(row.unf_exp & row.unf_care),
                    longint'(underflow_seen & row.unf_care));
    endtask

    always @(negedge local_clock) begin
        if (collecting) begin
            for (int i = 0; i < lane_count; i++) begin
                if (symbol_out[i] != skip_symbol) begin
                    received_q[i].push_back(symbol_out[i]);
                end
                if (skip_added[i]) begin
                    pulse_seen[i] = 1'b1;
                end
            end
        end
    end

    initial begin
        int limit;
        int total;
        wait (table_ready);
        total = 0;
        for (int t = 0; t < test_count; t++) begin
            total += tests[t].count;
        end
        limit = total * 8 + 200;
        repeat (limit) @(posedge local_clock);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        local_reset = 1'b0;
        lane_in = '0;
        lane_enable = '0;
        seed = 77;
        collecting = 1'b0;
        pulse_seen = '0;
        table_ready = 1'b0;

        // enable count gap interval stop order ovf care unf care add care rem care
        test_names[0] = "reset_state";
        tests[0] = '{2'b11, 0, 0, 6, 2'b00, 1'b0, 2'b00, 2'b11, 2'b00, 2'b11,
                     2'b00, 2'b11, 2'b00, 2'b11};
        test_names[1] = "lane_independence";
        tests[1] = '{2'b10, 48, 0, 6, 2'b00, 1'b1, 2'b00, 2'b11, 2'b00, 2'b10,
                     2'b00, 2'b01, 2'b00, 2'b01};
        test_names[2] = "pass_through";
        tests[2] = '{2'b11, 64, 0, 6, 2'b00, 1'b1, 2'b00, 2'b11, 2'b00, 2'b11,
                     2'b00, 2'b00, 2'b00, 2'b00};
        test_names[3] = "skip_insertion";
        tests[3] = '{2'b11, 64, 4, 4, 2'b00, 1'b1, 2'b00, 2'b11, 2'b00, 2'b00,
                     2'b11, 2'b11, 2'b00, 2'b00};
        test_names[4] = "skip_removal";
        tests[4] = '{2'b11, 96, 2, 4, 2'b00, 1'b0, 2'b00, 2'b00, 2'b00, 2'b00,
                     2'b00, 2'b00, 2'b11, 2'b11};
        test_names[5] = "underflow";
        tests[5] = '{2'b11, 48, 0, 6, 2'b01, 1'b1, 2'b00, 2'b11, 2'b01, 2'b11,
                     2'b00, 2'b00, 2'b00, 2'b00};
        table_ready = 1'b1;

        for (int t = 0; t < test_count; t++) begin
            current_test = test_names[t];
            for (int i = 0; i < lane_count; i++) begin
                sent_q[i].delete();
                received_q[i].delete();
                comma_sent[i] = 0;
            end
            pulse_seen = '0;
            reset_dut(tests[t].enable);
            check_reset_state();
            collecting = 1'b1;
            drive_symbols(tests[t]);
            collecting = 1'b0;
            check_results(tests[t]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* tests/elastic_chk.sv */
`timescale 1ns/1ns

module elastic_chk #(
    parameter int address_width = 4
) (
    input logic                   local_clock,
    input logic                   local_reset,
    input logic [address_width:0] read_pointer,
    input logic                   skip_added,
    input logic                   underflow
);

    logic [3:0] cycles_since_reset;

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            cycles_since_reset <= '0;
        end else if (cycles_since_reset != 4'hF) begin
            cycles_since_reset <= cycles_since_reset + 4'd1;
        end
    end

    // A skip is repeated twice, so the pulse is two cycles long
    skip_added_second_cycle: assert property (@(posedge local_clock) disable iff (!local_reset)
        $rose(skip_added) |=> skip_added)
        else $error("skip_added lasted a single cycle");

    skip_added_ends: assert property (@(posedge local_clock) disable iff (!local_reset)
        ($past(skip_added) && skip_added) |=> !skip_added)
        else $error("skip_added lasted more than two cycles");

    read_pointer_held: assert property (@(posedge local_clock) disable iff (!local_reset)
        skip_added |=> read_pointer == $past(read_pointer))
        else $error("read_pointer moved during a skip stall");

    no_early_underflow: assert property (@(posedge local_clock) disable iff (!local_reset)
        cycles_since_reset < 4'd8 |-> !underflow)
        else $error("underflow raised before reading started");

endmodule

bind buffer_read elastic_chk #(
    .address_width (address_width)
) chk_i (
    .local_clock  (local_clock),
    .local_reset  (local_reset),
    .read_pointer (read_pointer),
    .skip_added   (skip_added),
    .underflow    (underflow)
);

/* logic/elastic_top.sv */
`timescale 1ns/1ns

module elastic_top
    import elastic_pkg::*;
#(
    parameter int lane_count = 2,
    parameter int address_width = 4
) (
    input  logic                               local_clock,
    input  logic                               local_reset,
    input  lane_symbol_t [lane_count-1:0]      lane_in,
    input  logic         [lane_count-1:0]      lane_enable,
    output logic         [lane_count-1:0]      link_up,
    output symbol_t      [lane_count-1:0]      symbol_out,
    output logic         [lane_count-1:0]      skip_added,
    output logic         [lane_count-1:0]      overflow_seen,
    output logic         [lane_count-1:0]      underflow_seen,
    output logic         [lane_count-1:0][7:0] added_count,
    output logic         [lane_count-1:0][7:0] removed_count
);

    lane_symbol_t [lane_count-1:0] lane_symbol;
    lane_report_t [lane_count-1:0] lane_report;

    symbol_ingress #(
        .lane_count (lane_count)
    ) ingress_i (
        .local_clock (local_clock),
        .local_reset (local_reset),
        .lane_in     (lane_in),
        .lane_enable (lane_enable),
        .lane_out    (lane_symbol),
        .link_up     (link_up)
    );

    for (genvar lane = 0; lane < lane_count; lane++) begin : lanes
        lane_buffer #(
            .address_width (address_width)
        ) lane_i (
            .local_clock (local_clock),
            .local_reset (local_reset),
            .lane_in     (lane_symbol[lane]),
            .report      (lane_report[lane])
        );
    end

    lane_status #(
        .lane_count (lane_count)
    ) status_i (
        .local_clock    (local_clock),
        .local_reset    (local_reset),
        .report         (lane_report),
        .symbol_out     (symbol_out),
        .skip_added     (skip_added),
        .overflow_seen  (overflow_seen),
        .underflow_seen (underflow_seen),
        .added_count    (added_count),
        .removed_count  (removed_count)
    );

endmodule

/* logic/lane_status.sv */
`timescale 1ns/1ns

module lane_status
    import elastic_pkg::*;
#(
    parameter int lane_count = 2
) (
    input  logic                               local_clock,
    input  logic                               local_reset,
    input  lane_report_t [lane_count-1:0]      report,
    output symbol_t      [lane_count-1:0]      symbol_out,
    output logic         [lane_count-1:0]      skip_added,
    output logic         [lane_count-1:0]      overflow_seen,
    output logic         [lane_count-1:0]      underflow_seen,
    output logic         [lane_count-1:0][7:0] added_count,
    output logic         [lane_count-1:0][7:0] removed_count
);

    always_ff @(posedge local_clock) begin
        for (int i = 0; i < lane_count; i++) begin
            symbol_out[i] <= report[i].symbol;
        end
    end

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            skip_added <= '0;
            overflow_seen <= '0;
            underflow_seen <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                skip_added[i] <= report[i].skip_added;
                // Error flags stay set until the next reset
                if (report[i].overflow) begin
                    overflow_seen[i] <= 1'b1;
                end
                if (report[i].underflow) begin
                    underflow_seen[i] <= 1'b1;
                end
            end
        end
    end

    // Every cycle of skip_added puts one extra skip on the output
    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            added_count <= '0;
            removed_count <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                if (report[i].skip_added && added_count[i] != 8'hFF) begin
                    added_count[i] <= added_count[i] + 8'd1;
                end
                if (report[i].skip_removed && removed_count[i] != 8'hFF) begin
                    removed_count[i] <= removed_count[i] + 8'd1;
                end
            end
        end
    end

endmodule

/* logic/lane_buffer.sv */
`timescale 1ns/1ns

module lane_buffer
    import elastic_pkg::*;
#(
    parameter int address_width = 4,
    parameter int add_threshold = 5,
    parameter int remove_threshold = 11
) (
    input  logic         local_clock,
    input  logic         local_reset,
    input  lane_symbol_t lane_in,
    output lane_report_t report
);

    logic                     write_enable;
    logic [address_width-1:0] write_address;
    symbol_t                  write_data;
    logic [address_width:0]   write_pointer;
    logic [address_width:0]   write_pointer_sync;
    logic [address_width:0]   read_pointer;
    logic [address_width-1:0] read_address;
    symbol_t                  read_data;
    logic                     skip_added;
    logic                     skip_removed;
    logic                     overflow;
    logic                     underflow;

    symbol_write #(
        .address_width    (address_width),
        .remove_threshold (remove_threshold)
    ) write_i (
        .local_clock   (local_clock),
        .local_reset   (local_reset),
        .lane_in       (lane_in),
        .read_pointer  (read_pointer),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .write_pointer (write_pointer),
        .skip_removed  (skip_removed),
        .overflow      (overflow)
    );

    // The read port is registered, so while the pointer is held the address
    // steps back one slot and the skip itself is read again
    assign read_address = read_pointer[address_width-1:0] -
                          {{(address_width-1){1'b0}}, skip_added};

    symbol_ram #(
        .address_width (address_width)
    ) ram_i (
        .local_clock        (local_clock),
        .local_reset        (local_reset),
        .write_enable       (write_enable),
        .write_address      (write_address),
        .write_data         (write_data),
        .write_pointer      (write_pointer),
        .read_address       (read_address),
        .read_data          (read_data),
        .write_pointer_sync (write_pointer_sync)
    );

    buffer_read #(
        .address_width (address_width),
        .add_threshold (add_threshold)
    ) read_i (
        .local_clock        (local_clock),
        .local_reset        (local_reset),
        .data_out           (read_data),
        .write_pointer_sync (write_pointer_sync),
        .read_pointer       (read_pointer),
        .skip_added         (skip_added),
        .underflow          (underflow)
    );

    assign report = '{
        symbol:       read_data,
        skip_added:   skip_added,
        skip_removed: skip_removed,
        overflow:     overflow,
        underflow:    underflow
    };

endmodule

/* logic/buffer_read.sv */
`timescale 1ns/1ns

module buffer_read
    import elastic_pkg::*;
#(
    parameter int address_width = 4,
    parameter int add_threshold = 5
) (
    input  logic                   local_clock,
    input  logic                   local_reset,
    input  symbol_t                data_out,
    input  logic [address_width:0] write_pointer_sync,
    output logic [address_width:0] read_pointer,
    output logic                   skip_added,
    output logic                   underflow
);

    localparam int depth = 1 << address_width;
    localparam int start_delay = 7;

    read_state_t              current_state;
    read_state_t              next_state;
    logic                     empty;
    logic                     prev_empty;
    logic [address_width-1:0] fill_level;
    logic [2:0]               start_count;

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            current_state <= waiting_for_comma;
        end else begin
            current_state <= next_state;
        end
    end

    // A skip right after a comma is stretched when the buffer runs low
    always_comb begin
        skip_added = 1'b0;
        next_state = waiting_for_comma;
        case (current_state)
            waiting_for_comma: begin
                if (data_out == comma_symbol) begin
                    next_state = comma_detected;
                end
            end
            comma_detected: begin
                if (data_out == skip_symbol && fill_level < add_threshold) begin
                    next_state = skip_and_stall;
                    skip_added = 1'b1;
                end
            end
            skip_and_stall: begin
                next_state = skip_and_continue;
                skip_added = 1'b1;
            end
            skip_and_continue: begin
                next_state = waiting_for_comma;
            end
            default: begin
                next_state = waiting_for_comma;
            end
        endcase
    end

    // Give the write side a head start before reading begins
    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            start_count <= '0;
        end else if (start_count < start_delay) begin
            start_count <= start_count + 3'd1;
        end
    end

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            read_pointer <= '0;
        end else if (start_count == start_delay && !skip_added) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            fill_level <= '0;
        end else begin
            fill_level <= write_pointer_sync[address_width-1:0] -
                          read_pointer[address_width-1:0];
        end
    end

    // Reading past the write pointer shows up as an empty buffer then a fill of depth-1
    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            empty <= 1'b0;
            prev_empty <= 1'b0;
            underflow <= 1'b0;
        end else begin
            empty <= write_pointer_sync == read_pointer;
            prev_empty <= empty;
            underflow <= prev_empty && fill_level == address_width'(depth - 1);
        end
    end

endmodule

/* logic/symbol_ram.sv */
`timescale 1ns/1ns

module symbol_ram
    import elastic_pkg::*;
#(
    parameter int address_width = 4
) (
    input  logic                     local_clock,
    input  logic                     local_reset,
    input  logic                     write_enable,
    input  logic [address_width-1:0] write_address,
    input  symbol_t                  write_data,
    input  logic [address_width:0]   write_pointer,
    input  logic [address_width-1:0] read_address,
    output symbol_t                  read_data,
    output logic [address_width:0]   write_pointer_sync
);

    localparam int depth = 1 << address_width;

    symbol_t                mem [depth];
    logic [address_width:0] write_pointer_meta;

    always_ff @(posedge local_clock) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
        read_data <= mem[read_address];
    end

    // Two stages, as if the pointer crossed from a recovered clock
    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            write_pointer_meta <= '0;
            write_pointer_sync <= '0;
        end else begin
            write_pointer_meta <= write_pointer;
            write_pointer_sync <= write_pointer_meta;
        end
    end

endmodule

/* logic/symbol_write.sv */
`timescale 1ns/1ns

module symbol_write
    import elastic_pkg::*;
#(
    parameter int address_width = 4,
    parameter int remove_threshold = 11
) (
    input  logic                     local_clock,
    input  logic                     local_reset,
    input  lane_symbol_t             lane_in,
    input  logic [address_width:0]   read_pointer,
    output logic                     write_enable,
    output logic [address_width-1:0] write_address,
    output symbol_t                  write_data,
    output logic [address_width:0]   write_pointer,
    output logic                     skip_removed,
    output logic                     overflow
);

    localparam int depth = 1 << address_width;

    logic                     after_comma;
    logic [address_width-1:0] fill;
    logic                     drop_skip;
    logic                     buffer_full;

    // Fill is taken modulo the buffer depth, the same way the read side does it
    assign fill = write_pointer[address_width-1:0] - read_pointer[address_width-1:0];

    assign drop_skip = lane_in.valid && after_comma && lane_in.symbol == skip_symbol &&
                       fill >= remove_threshold;
    assign buffer_full = fill == address_width'(depth - 1);

    assign write_enable = lane_in.valid && !drop_skip && !buffer_full;
    assign overflow = lane_in.valid && !drop_skip && buffer_full;
    assign skip_removed = drop_skip;

    assign write_address = write_pointer[address_width-1:0];
    assign write_data = lane_in.symbol;

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            after_comma <= 1'b0;
        end else if (lane_in.valid) begin
            // Only the symbol right after a comma is a candidate for removal
            after_comma <= lane_in.symbol == comma_symbol;
        end
    end

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            write_pointer <= '0;
        end else if (write_enable) begin
            write_pointer <= write_pointer + 1'b1;
        end
    end

endmodule

/* logic/symbol_ingress.sv */
`timescale 1ns/1ns

module symbol_ingress
    import elastic_pkg::*;
#(
    parameter int lane_count = 2
) (
    input  logic                           local_clock,
    input  logic                           local_reset,
    input  lane_symbol_t [lane_count-1:0] lane_in,
    input  logic         [lane_count-1:0] lane_enable,
    output lane_symbol_t [lane_count-1:0] lane_out,
    output logic         [lane_count-1:0] link_up
);

    localparam int link_commas = 4;

    logic [lane_count-1:0][2:0] comma_count;

    always_ff @(posedge local_clock or negedge local_reset) begin
        if (!local_reset) begin
            lane_out <= '0;
            comma_count <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                lane_out[i].symbol <= lane_in[i].symbol;
                lane_out[i].valid <= lane_in[i].valid && lane_enable[i];
                // A disabled lane starts link training from scratch
                if (!lane_enable[i]) begin
                    comma_count[i] <= '0;
                end else if (lane_in[i].valid && lane_in[i].symbol == comma_symbol &&
                             comma_count[i] != 3'(link_commas)) begin
                    comma_count[i] <= comma_count[i] + 3'd1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            link_up[i] = comma_count[i] == 3'(link_commas);
        end
    end

endmodule

/* logic/elastic_pkg.sv */
package elastic_pkg;

    // Control codes of the 10-bit coded link
    localparam logic [9:0] comma_symbol = 10'h1BC;
    localparam logic [9:0] skip_symbol = 10'h1A1;

    typedef logic [9:0] symbol_t;

    // One symbol slot as it leaves the ingress stage
    typedef struct packed {
        symbol_t symbol;
        logic    valid;
    } lane_symbol_t;

    // Everything a lane hands to the status collector in one cycle
    typedef struct packed {
        symbol_t symbol;
        logic    skip_added;
        logic    skip_removed;
        logic    overflow;
        logic    underflow;
    } lane_report_t;

    // Read side watches for a comma, then a skip it may repeat
    typedef enum logic [1:0] {
        waiting_for_comma = 2'd0,
        comma_detected    = 2'd1,
        skip_and_stall    = 2'd2,
        skip_and_continue = 2'd3
    } read_state_t;

endpackage
